// ==== rtl/act_buffer.sv ====
`timescale 1ns/1ps

`include "sparse_row_macros.svh"

module act_buffer import sparse_row_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               wr_req_act_flag,
  input  row_flags_t         wr_data_act_flag,
  input  logic               wr_req_act,
  input  logic [`ACT_W-1:0]  wr_data_act,
  input  logic [`IDX_W-1:0]  row_index,
  input  logic [`IDX_W-1:0]  act_index,
  output row_flags_t         row_flags,
  output logic [`ACT_W-1:0]  serial_out
);

  // ==================================================
  // storage
  // ==================================================
  row_flags_t        flag_mem [`ROW_NUM];
  logic [`ACT_W-1:0] act_mem  [`ROW_NUM * `ROW_LEN];

  logic [`IDX_W-1:0]      wr_addr_act_flag;
  logic [`ACT_ADDR_W-1:0] wr_addr_act;
  logic [`ACT_ADDR_W-1:0] rd_addr_act;

  // ==================================================
  // write side
  // ==================================================
  // flag words, one per row
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wr_addr_act_flag <= '0;
    end else if (wr_req_act_flag) begin
      wr_addr_act_flag <= wr_addr_act_flag + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req_act_flag) begin
      flag_mem[wr_addr_act_flag] <= wr_data_act_flag;
    end
  end

  // activation bytes, row major
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wr_addr_act <= '0;
    end else if (wr_req_act) begin
      wr_addr_act <= wr_addr_act + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req_act) begin
      act_mem[wr_addr_act] <= wr_data_act;
    end
  end

  // ==================================================
  // read side
  // ==================================================
  // row in the upper nibble, column in the lower
  assign rd_addr_act = {row_index, act_index};

  assign row_flags  = flag_mem[row_index];
  assign serial_out = act_mem[rd_addr_act];

endmodule

// ==== rtl/flag_scanner.sv ====
`timescale 1ns/1ps

`include "sparse_row_macros.svh"

module flag_scanner import sparse_row_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              shift,
  input  row_flags_t        row_flags,
  output logic [`IDX_W-1:0] act_index,
  output logic [`CNT_W-1:0] row_val_num,
  output logic              zero_flag,
  output logic              last_item
);

  row_flags_t remain_flags;
  row_flags_t next_flags;

  function automatic logic [`CNT_W-1:0] count_ones(input row_flags_t flags);
    logic [`CNT_W-1:0] total;
    total = '0;
    for (int i = 0; i < `ROW_LEN; i++) begin
      total = total + `CNT_W'(flags[i]);
    end
    return total;
  endfunction

  // ==================================================
  // remaining flags and row count
  // ==================================================
  // drop the lowest set bit
  assign next_flags = remain_flags & (remain_flags - 1'b1);

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      remain_flags <= '0;
      row_val_num  <= '0;
    end else if (load) begin
      remain_flags <= row_flags;
      row_val_num  <= count_ones(row_flags);
    end else if (shift) begin
      remain_flags <= next_flags;
    end
  end

  // ==================================================
  // lowest set column
  // ==================================================
  // scan from the top so the lowest hit wins
  always_comb begin
    act_index = '0;
    for (int i = `ROW_LEN - 1; i >= 0; i--) begin
      if (remain_flags[i]) begin
        act_index = `IDX_W'(i);
      end
    end
  end

  assign zero_flag = (row_val_num == '0);

  // zero or one bit left
  assign last_item = (next_flags == '0);

  load_shift_exclusive: assert property (
    @(posedge clk) disable iff (!reset)
    !(load && shift)
  ) else $error("flag_scanner: load and shift in the same cycle");

endmodule

// ==== rtl/row_sequencer.sv ====
`timescale 1ns/1ps

`include "sparse_row_macros.svh"

module row_sequencer import sparse_row_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic              wait_state,
  input  logic              last_item,
  output logic              en,
  output seq_state_t        state,
  output logic [`IDX_W-1:0] row_index,
  output logic              load,
  output logic              shift,
  output logic              row_cal_done
);

  seq_state_t next_state;
  logic       last_row;

  assign last_row = (row_index == `IDX_W'(`ROW_NUM - 1));

  // ==================================================
  // start strobe
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      en <= 1'b0;
    end else begin
      en <= start;
    end
  end

  // ==================================================
  // state machine
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= PREP;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      PREP: begin
        if (en) begin
          next_state = TRAN;
        end
      end
      // flag word is captured here, one cycle only
      TRAN: begin
        next_state = wait_state ? WAIT : COMP;
      end
      WAIT: begin
        if (!wait_state) begin
          next_state = COMP;
        end
      end
      COMP: begin
        if (row_cal_done) begin
          next_state = last_row ? PREP : TRAN;
        end
      end
      default: begin
        next_state = PREP;
      end
    endcase
  end

  // ==================================================
  // scanner control and row completion
  // ==================================================
  assign load  = (state == TRAN);
  assign shift = (state == COMP);

  // an empty row still gets one COMP cycle
  assign row_cal_done = (state == COMP) && last_item;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      row_index <= '0;
    end else if (row_cal_done) begin
      row_index <= last_row ? '0 : row_index + 1'b1;
    end
  end

endmodule

// ==== rtl/sparse_row_macros.svh ====
`ifndef SPARSE_ROW_MACROS_SVH
`define SPARSE_ROW_MACROS_SVH

// ==================================================
// data widths
// ==================================================
// one activation or one weight
`define ACT_W 8

// ==================================================
// activation store geometry
// ==================================================
`define ROW_LEN 16
`define ROW_NUM 16
// column or row index
`define IDX_W 4
// non-zero count per row, 0 to 16
`define CNT_W 5
`define ACT_ADDR_W 8

// ==================================================
// kernel
// ==================================================
`define KERNEL_SIZE 9
`define WEI_ADDR_W 4

`endif

// ==== rtl/sparse_row_pkg.sv ====
`include "sparse_row_macros.svh"

package sparse_row_pkg;

  // sequencer states
  typedef enum logic [1:0] {
    PREP = 2'd0,
    TRAN = 2'd1,
    WAIT = 2'd2,
    COMP = 2'd3
  } seq_state_t;

  // one bit per column, set for a non-zero activation
  typedef logic [`ROW_LEN-1:0] row_flags_t;

endpackage

// ==== rtl/sparse_row_top.sv ====
`timescale 1ns/1ps

`include "sparse_row_macros.svh"

module sparse_row_top import sparse_row_pkg::*; (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            wr_req_act_flag,
  input  row_flags_t                      wr_data_act_flag,
  input  logic                            wr_req_act,
  input  logic [`ACT_W-1:0]               wr_data_act,
  input  logic                            wr_req_wei,
  input  logic [`ACT_W-1:0]               wr_data_wei,
  input  logic                            start,
  input  logic                            wait_state,
  output logic                            en,
  output seq_state_t                      state,
  output logic [`IDX_W-1:0]               row_index,
  output logic [`IDX_W-1:0]               act_index,
  output logic [`ACT_W-1:0]               serial_out,
  output logic [`CNT_W-1:0]               row_val_num,
  output logic                            zero_flag,
  output logic                            row_cal_done,
  output logic [`ACT_W*`KERNEL_SIZE-1:0]  parallel_out
);

  row_flags_t row_flags;
  logic       load;
  logic       shift;
  logic       last_item;

  // ==================================================
  // input side
  // ==================================================
  act_buffer i_act_buffer (
    .clk              (clk),
    .reset            (reset),
    .wr_req_act_flag  (wr_req_act_flag),
    .wr_data_act_flag (wr_data_act_flag),
    .wr_req_act       (wr_req_act),
    .wr_data_act      (wr_data_act),
    .row_index        (row_index),
    .act_index        (act_index),
    .row_flags        (row_flags),
    .serial_out       (serial_out)
  );

  // ==================================================
  // processing
  // ==================================================
  row_sequencer i_row_sequencer (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .wait_state   (wait_state),
    .last_item    (last_item),
    .en           (en),
    .state        (state),
    .row_index    (row_index),
    .load         (load),
    .shift        (shift),
    .row_cal_done (row_cal_done)
  );

  flag_scanner i_flag_scanner (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .shift       (shift),
    .row_flags   (row_flags),
    .act_index   (act_index),
    .row_val_num (row_val_num),
    .zero_flag   (zero_flag),
    .last_item   (last_item)
  );

  // ==================================================
  // output side
  // ==================================================
  weight_buffer i_weight_buffer (
    .clk          (clk),
    .reset        (reset),
    .wr_req_wei   (wr_req_wei),
    .wr_data_wei  (wr_data_wei),
    .parallel_out (parallel_out)
  );

  // stores are only filled while the sequencer is idle
  no_write_in_pass: assert property (
    @(posedge clk) disable iff (!reset)
    (wr_req_act_flag || wr_req_act || wr_req_wei) |-> (state == PREP)
  ) else $error("sparse_row_top: store write during a pass");

endmodule

// ==== rtl/weight_buffer.sv ====
`timescale 1ns/1ps

`include "sparse_row_macros.svh"

module weight_buffer (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            wr_req_wei,
  input  logic [`ACT_W-1:0]               wr_data_wei,
  output logic [`ACT_W*`KERNEL_SIZE-1:0]  parallel_out
);

  logic [`ACT_W-1:0]      wei_mem [`KERNEL_SIZE];
  logic [`WEI_ADDR_W-1:0] wr_addr_wei;

  // ==================================================
  // kernel store
  // ==================================================
  // counter wraps after the ninth weight
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wr_addr_wei <= '0;
    end else if (wr_req_wei) begin
      if (wr_addr_wei == `WEI_ADDR_W'(`KERNEL_SIZE - 1)) begin
        wr_addr_wei <= '0;
      end else begin
        wr_addr_wei <= wr_addr_wei + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `KERNEL_SIZE; i++) begin
        wei_mem[i] <= '0;
      end
    end else if (wr_req_wei) begin
      wei_mem[wr_addr_wei] <= wr_data_wei;
    end
  end

  // whole kernel to the PE array, entry 0 lowest
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      parallel_out <= '0;
    end else begin
      for (int i = 0; i < `KERNEL_SIZE; i++) begin
        parallel_out[i*`ACT_W +: `ACT_W] <= wei_mem[i];
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then grade the log
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_sparse_row \
  -f verilog.f > "$LOG" 2>&1 &&
  ./obj_dir/Vtb_sparse_row >> "$LOG" 2>&1 ||
  { echo "build or simulation error, see $LOG"; exit 1; }

grep -q "Verification failed" "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -q "Verification passed" "$LOG" || { echo "no result found in $LOG"; exit 1; }
echo "simulation passed"
exit 0

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release lands just after an edge, like the other inputs
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b1;
  end

endmodule

// ==== sim/tb_sparse_row.sv ====
`timescale 1ns/1ps

`include "sparse_row_macros.svh"

module tb_sparse_row import sparse_row_pkg::*; ();

  logic                           clk;
  logic                           reset;
  logic                           wr_req_act_flag;
  row_flags_t                     wr_data_act_flag;
  logic                           wr_req_act;
  logic [`ACT_W-1:0]              wr_data_act;
  logic                           wr_req_wei;
  logic [`ACT_W-1:0]              wr_data_wei;
  logic                           start;
  logic                           wait_state;
  logic                           en;
  seq_state_t                     state;
  logic [`IDX_W-1:0]              row_index;
  logic [`IDX_W-1:0]              act_index;
  logic [`ACT_W-1:0]              serial_out;
  logic [`CNT_W-1:0]              row_val_num;
  logic                           zero_flag;
  logic                           row_cal_done;
  logic [`ACT_W*`KERNEL_SIZE-1:0] parallel_out;

  // model of what was written
  row_flags_t                     model_flags [`ROW_NUM];
  logic [`ACT_W-1:0]              model_act [`ROW_NUM * `ROW_LEN];
  logic [`ACT_W*`KERNEL_SIZE-1:0] model_kernel;

  // emissions seen so far in the current row
  int                emit_cnt;
  logic              have_prev;
  logic [`IDX_W-1:0] prev_idx;

  int     err_count;
  int     tests_run;
  int     tests_failed;
  integer seed;
  logic   timed_out;
  string  timeout_what;

  tb_clock #(.period_ns(4), .reset_cycles(10)) i_tb_clock (.clk(clk), .reset(reset));

  sparse_row_top i_sparse_row_top (
    .clk(clk), .reset(reset),
    .wr_req_act_flag(wr_req_act_flag), .wr_data_act_flag(wr_data_act_flag),
    .wr_req_act(wr_req_act), .wr_data_act(wr_data_act),
    .wr_req_wei(wr_req_wei), .wr_data_wei(wr_data_wei),
    .start(start), .wait_state(wait_state),
    .en(en), .state(state), .row_index(row_index), .act_index(act_index),
    .serial_out(serial_out), .row_val_num(row_val_num), .zero_flag(zero_flag),
    .row_cal_done(row_cal_done), .parallel_out(parallel_out)
  );

  always @(posedge clk) begin
    if (state == TRAN) begin
      emit_cnt  <= 0;
      have_prev <= 1'b0;
    end else if (state == COMP && !zero_flag) begin
      emit_cnt  <= emit_cnt + 1;
      have_prev <= 1'b1;
      prev_idx  <= act_index;
    end
  end

  function automatic void count_error(input string msg);
    err_count++;
    $display("ERR %0t: %s", $time, msg);
  endfunction

  // ==================================================
  // checks
  // ==================================================
  reset_values: assert property (@(posedge clk) $rose(reset) |-> (state == PREP && !en &&
    !row_cal_done && row_index == '0 && row_val_num == '0 && zero_flag && parallel_out == '0))
  else count_error("outputs not at reset values");

  kernel_packed: assert property (@(posedge clk) disable iff (!reset)
    $fell(wr_req_wei) |=> parallel_out == model_kernel)
  else count_error($sformatf("parallel_out %0h, model kernel %0h",
    $sampled(parallel_out), model_kernel));

  elem_flag_set: assert property (@(posedge clk) disable iff (!reset)
    (state == COMP && !zero_flag) |-> model_flags[row_index][act_index])
  else count_error($sformatf("row %0d column %0d emitted with flag clear",
    $sampled(row_index), $sampled(act_index)));

  elem_value: assert property (@(posedge clk) disable iff (!reset)
    (state == COMP && !zero_flag) |-> serial_out == model_act[{row_index, act_index}])
  else count_error($sformatf("serial_out %0h at row %0d column %0d is wrong",
    $sampled(serial_out), $sampled(row_index), $sampled(act_index)));

  elem_ascending: assert property (@(posedge clk) disable iff (!reset)
    (state == COMP && !zero_flag && have_prev) |-> act_index > prev_idx)
  else count_error("column index not rising within row");

  count_matches: assert property (@(posedge clk) disable iff (!reset)
    (state == COMP) |-> row_val_num == `CNT_W'($countones(model_flags[row_index])))
  else count_error($sformatf("row_val_num %0d differs from model count",
    $sampled(row_val_num)));

  zero_only_row3: assert property (@(posedge clk) disable iff (!reset)
    (state == COMP) |-> zero_flag == (row_index == `IDX_W'(3)))
  else count_error($sformatf("zero_flag wrong for row %0d", $sampled(row_index)));

  emitted_all: assert property (@(posedge clk) disable iff (!reset)
    row_cal_done |-> emit_cnt + (zero_flag ? 0 : 1) == $countones(model_flags[row_index]))
  else count_error($sformatf("row %0d emitted the wrong number of elements",
    $sampled(row_index)));

  row7_full: assert property (@(posedge clk) disable iff (!reset)
    (row_cal_done && row_index == `IDX_W'(7)) |-> emit_cnt == 15 && !zero_flag)
  else count_error("row 7 did not emit 16 elements");

  en_after_start: assert property (@(posedge clk) disable iff (!reset) start |=> en)
  else count_error("en missing one cycle after start");

  tran_after_en: assert property (@(posedge clk) disable iff (!reset)
    (en && state == PREP) |=> state == TRAN)
  else count_error("no TRAN one cycle after en");

  next_row_tran: assert property (@(posedge clk) disable iff (!reset)
    (row_cal_done && row_index != `IDX_W'(15)) |=>
    (state == TRAN && row_index == `IDX_W'($past(row_index) + 1'b1)))
  else count_error("next row did not start in TRAN");

  last_row_prep: assert property (@(posedge clk) disable iff (!reset)
    (row_cal_done && row_index == `IDX_W'(15)) |=> (state == PREP && row_index == '0))
  else count_error("no return to PREP after row 15");

  tran_to_wait: assert property (@(posedge clk) disable iff (!reset)
    (state == TRAN && wait_state) |=> state == WAIT)
  else count_error("TRAN ignored wait_state");

  wait_holds: assert property (@(posedge clk) disable iff (!reset)
    (state == WAIT && wait_state) |=> state == WAIT)
  else count_error("left WAIT while wait_state high");

  wait_release: assert property (@(posedge clk) disable iff (!reset)
    (state == WAIT && !wait_state) |=> state == COMP)
  else count_error("COMP did not follow wait_state low");

  // ==================================================
  // helper tasks
  // ==================================================
  task automatic abort_on_timeout(input string what);
    timeout_what = what;
    timed_out    = 1'b1;
    forever @(posedge clk);
  endtask

  task automatic wait_until_state(input seq_state_t target, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (state != target && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (state != target) begin
      abort_on_timeout(what);
    end
  endtask

  task automatic wait_row_done(input logic [`IDX_W-1:0] row, input int limit);
    int cycles;
    cycles = 0;
    while (!(row_cal_done && row_index == row) && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!(row_cal_done && row_index == row)) begin
      abort_on_timeout("row completion");
    end
  endtask

  task automatic fill_stores();
    for (int r = 0; r < `ROW_NUM; r++) begin
      if (r == 3) begin
        model_flags[r] = '0;
      end else if (r == 7) begin
        model_flags[r] = '1;
      end else begin
        model_flags[r] = row_flags_t'($random(seed) & $random(seed)) | row_flags_t'(1);
      end
      wr_req_act_flag  = 1'b1;
      wr_data_act_flag = model_flags[r];
      @(posedge clk);
      #1;
    end
    wr_req_act_flag = 1'b0;
    // zeros where the flag is clear, non-zero bytes elsewhere
    for (int a = 0; a < `ROW_NUM * `ROW_LEN; a++) begin
      model_act[a] = model_flags[a / `ROW_LEN][a % `ROW_LEN] ?
                     (`ACT_W'($random(seed)) | `ACT_W'(1)) : '0;
      wr_req_act  = 1'b1;
      wr_data_act = model_act[a];
      @(posedge clk);
      #1;
    end
    wr_req_act = 1'b0;
  endtask

  task automatic fill_kernel();
    for (int k = 0; k < `KERNEL_SIZE; k++) begin
      model_kernel[k*`ACT_W +: `ACT_W] = `ACT_W'($random(seed));
      wr_req_wei  = 1'b1;
      wr_data_wei = model_kernel[k*`ACT_W +: `ACT_W];
      @(posedge clk);
      #1;
    end
    wr_req_wei = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = err_count - errs_before;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %-14s %s, %0d assertion errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  always @(posedge timed_out) begin
    $display("timeout while waiting for %s", timeout_what);
    $display("Verification failed");
    $finish;
  end

  // ==================================================
  // stimulus
  // ==================================================
  initial begin
    int mark;
    int cycles;
    wr_req_act_flag = 1'b0;
    wr_data_act_flag = '0;
    wr_req_act = 1'b0;
    wr_data_act = '0;
    wr_req_wei = 1'b0;
    wr_data_wei = '0;
    start = 1'b0;
    wait_state = 1'b0;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    seed = 32'h374d_ba19;
    model_kernel = '0;
    mark = 0;
    cycles = 0;
    while (reset !== 1'b1 && cycles < 50) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (reset !== 1'b1) begin
      abort_on_timeout("reset release");
    end
    repeat (2) @(posedge clk);
    #1;
    report_test("reset state", mark);
    mark = err_count;
    fill_stores();
    fill_kernel();
    repeat (3) @(posedge clk);
    #1;
    report_test("kernel output", mark);
    // plain pass over all rows
    mark = err_count;
    pulse_start();
    wait_until_state(TRAN, 10, "first TRAN");
    wait_until_state(PREP, 1000, "end of first pass");
    report_test("full pass", mark);
    // second pass with row 5 held in WAIT
    mark = err_count;
    pulse_start();
    wait_row_done(`IDX_W'(4), 500);
    wait_state = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    wait_state = 1'b0;
    wait_until_state(PREP, 1000, "end of second pass");
    report_test("back-pressure", mark);
    $display("tests run %0d, tests failed %0d, assertion errors %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/sparse_row_pkg.sv
rtl/act_buffer.sv
rtl/flag_scanner.sv
rtl/row_sequencer.sv
rtl/weight_buffer.sv
rtl/sparse_row_top.sv
sim/tb_clock.sv
sim/tb_sparse_row.sv
